/* files.f */
source/bp_pkg.sv
source/bp_resolve_if.sv
source/bp_decode.sv
source/pht_ghr.sv
source/btb.sv
source/gshare_bp.sv
verification/tb_clock.sv
verification/gshare_bp_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= gshare_bp_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --top-module $(TOP)

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the simulator is the test result
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

/* verification/gshare_bp_tb.sv */
// Gshare predictor testbench
`timescale 1ns/100ps

module gshare_bp_tb;
  import bp_pkg::*;

  // Must match the DUT defaults
  localparam int unsigned PHT_ENTRIES = 64;
  localparam int unsigned BTB_ENTRIES = 16;
  localparam int unsigned GHR_BITS    = 6;
  localparam int unsigned PHT_IDX     = $clog2(PHT_ENTRIES);
  localparam int unsigned BTB_IDX     = $clog2(BTB_ENTRIES);
  localparam int unsigned N_DIRECTED  = 40;
  localparam int unsigned N_RANDOM    = 3000;
  // Cycle budget x 100 ns x 2, plus 1 us
  localparam int unsigned TIMEOUT_NS  = (N_DIRECTED + N_RANDOM) * 200 + 1000;

  logic       clk;
  logic       rst_n;
  logic       stall;
  logic       fetch_valid;
  addr_t      pc;
  inst_t      inst;
  logic       resolve_valid;
  addr_t      resolve_pc;
  logic       resolve_taken;
  addr_t      resolve_target;
  addr_t      pred_pc;
  logic       pred_taken;
  pred_kind_e pred_kind;

  // ========================================
  // Reference model state
  // ========================================
  ctr_t                m_ctr    [PHT_ENTRIES];
  logic [GHR_BITS-1:0] m_ghr;
  logic                m_valid  [BTB_ENTRIES];
  addr_t               m_tag    [BTB_ENTRIES];
  addr_t               m_target [BTB_ENTRIES];
  logic [31:0]         rng_state;

  tb_clock i_tb_clock (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  gshare_bp i_gshare_bp (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .stall_i          (stall),
    .fetch_valid_i    (fetch_valid),
    .pc_i             (pc),
    .inst_i           (inst),
    .resolve_valid_i  (resolve_valid),
    .resolve_pc_i     (resolve_pc),
    .resolve_taken_i  (resolve_taken),
    .resolve_target_i (resolve_target),
    .pred_pc_o        (pred_pc),
    .pred_taken_o     (pred_taken),
    .pred_kind_o      (pred_kind)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // Word index XOR history
  function automatic int pht_index(input addr_t a, input logic [GHR_BITS-1:0] h);
    logic [31:0]        word;
    logic [PHT_IDX-1:0] hist;
    word = a >> 2;
    hist = PHT_IDX'(h);
    return int'(word[PHT_IDX-1:0] ^ hist);
  endfunction

  function automatic int btb_index(input addr_t a);
    logic [31:0] word;
    word = a >> 2;
    return int'(word[BTB_IDX-1:0]);
  endfunction

  function automatic addr_t btb_tag(input addr_t a);
    return a >> (2 + BTB_IDX);
  endfunction

  // Sign-extended J-type immediate
  function automatic addr_t jal_offset(input inst_t w);
    logic [20:0] imm;
    imm = {w[31], w[19:12], w[20], w[30:21], 1'b0};
    return {{11{imm[20]}}, imm};
  endfunction

  // Small PC pool with two tag bits over eight BTB slots
  function automatic addr_t pool_pc(input logic [4:0] s);
    return 32'h0000_1000 + (addr_t'(s[4:3]) << 6) + (addr_t'(s[2:0]) << 2);
  endfunction

  function automatic inst_t make_inst(input logic [1:0] sel, input logic [31:0] r);
    case (sel)
      2'd2:    return {r[31:7], 7'b1101111};
      2'd3:    return {r[31:7], 7'b0010011};
      default: return {r[31:7], 7'b1100011};
    endcase
  endfunction

  // ========================================
  // Compare tasks
  // ========================================
  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      $display("Test failed");
      $fatal(1, "Output mismatch");
    end
  endtask

  task automatic check_kind(input string name, input pred_kind_e got,
                            input pred_kind_e exp);
    if (got !== exp) begin
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      $display("Test failed");
      $fatal(1, "Output mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      $display("Test failed");
      $fatal(1, "Output mismatch");
    end
  endtask

  // Model update from the inputs the DUT sampled at this edge
  task automatic apply_edge();
    int pi;
    int bi;
    if (!rst_n) begin
      m_ghr = '0;
      for (int i = 0; i < PHT_ENTRIES; i++) m_ctr[i] = CTR_RESET;
      for (int i = 0; i < BTB_ENTRIES; i++) m_valid[i] = 1'b0;
    end else if (resolve_valid && !stall) begin
      pi = pht_index(resolve_pc, m_ghr);
      if (resolve_taken && m_ctr[pi] != 2'b11) m_ctr[pi] = m_ctr[pi] + 2'b01;
      else if (!resolve_taken && m_ctr[pi] != 2'b00) m_ctr[pi] = m_ctr[pi] - 2'b01;
      m_ghr = {m_ghr[GHR_BITS-2:0], resolve_taken};
      // Only taken branches allocate
      if (resolve_taken) begin
        bi = btb_index(resolve_pc);
        m_valid[bi]  = 1'b1;
        m_tag[bi]    = btb_tag(resolve_pc);
        m_target[bi] = resolve_target;
      end
    end
  endtask

  task automatic check_outputs();
    addr_t      exp_pc;
    logic       exp_taken;
    pred_kind_e exp_kind;
    int         bi;
    exp_pc    = pc + 32'd4;
    exp_taken = 1'b0;
    exp_kind  = PRED_SEQ;
    bi        = btb_index(pc);
    if (fetch_valid && !stall) begin
      if (inst[6:0] == 7'b1101111) begin
        exp_pc    = pc + jal_offset(inst);
        exp_taken = 1'b1;
        exp_kind  = PRED_JAL;
      end else if (inst[6:0] == 7'b1100011 && m_ctr[pht_index(pc, m_ghr)][1] &&
                   m_valid[bi] && m_tag[bi] == btb_tag(pc)) begin
        exp_pc    = m_target[bi];
        exp_taken = 1'b1;
        exp_kind  = PRED_BRANCH;
      end
    end
    check_addr("pred_pc_o", pred_pc, exp_pc);
    check_bit("pred_taken_o", pred_taken, exp_taken);
    check_kind("pred_kind_o", pred_kind, exp_kind);
  endtask

  // Drive at the rising edge and check at the falling edge
  task automatic run_cycle(input logic fv, input logic st, input addr_t p, input inst_t w,
                           input logic rv, input addr_t rp, input logic rt,
                           input addr_t rtg);
    @(posedge clk);
    apply_edge();
    fetch_valid    <= fv;
    stall          <= st;
    pc             <= p;
    inst           <= w;
    resolve_valid  <= rv;
    resolve_pc     <= rp;
    resolve_taken  <= rt;
    resolve_target <= rtg;
    @(negedge clk);
    check_outputs();
  endtask

  task automatic fetch_only(input addr_t p, input inst_t w);
    run_cycle(1'b1, 1'b0, p, w, 1'b0, '0, 1'b0, '0);
  endtask

  task automatic report_only(input addr_t rp, input logic rt, input addr_t rtg);
    run_cycle(1'b0, 1'b0, 32'h0000_0100, '0, 1'b1, rp, rt, rtg);
  endtask

  // ========================================
  // Watchdog
  // ========================================
  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog expired after %0d ns without finishing", TIMEOUT_NS);
    $display("Test failed");
    $fatal(1, "Watchdog expired");
  end

  initial begin
    logic [31:0] r;
    addr_t       bp_pc;
    rng_state      = 32'he1a6_95cd;
    stall          = 1'b0;
    fetch_valid    = 1'b0;
    pc             = '0;
    inst           = '0;
    resolve_valid  = 1'b0;
    resolve_pc     = '0;
    resolve_taken  = 1'b0;
    resolve_target = '0;
    bp_pc          = 32'h0000_2040;

    // Reset and then branches on empty tables
    repeat (3) run_cycle(1'b0, 1'b0, '0, '0, 1'b0, '0, 1'b0, '0);
    for (int i = 0; i < 4; i++) begin
      fetch_only(bp_pc + addr_t'(4 * i), make_inst(2'd0, next_rand()));
      check_kind("pred_kind_o", pred_kind, PRED_SEQ);
    end

    // JAL both directions
    fetch_only(bp_pc, make_inst(2'd2, 32'h8000_0000 | next_rand()));
    fetch_only(bp_pc, make_inst(2'd2, 32'h7fff_ffff & next_rand()));

    // Enough taken reports to fill the history and saturate its counter
    repeat (8) report_only(bp_pc, 1'b1, 32'h0000_3000);
    fetch_only(bp_pc, make_inst(2'd0, next_rand()));
    check_kind("pred_kind_o", pred_kind, PRED_BRANCH);
    check_addr("pred_pc_o", pred_pc, 32'h0000_3000);

    // Other tag in the same BTB slot and PHT index
    fetch_only(bp_pc ^ 32'h0001_0000, make_inst(2'd0, next_rand()));
    check_kind("pred_kind_o", pred_kind, PRED_SEQ);

    // Stalled report with a new target must not land
    run_cycle(1'b1, 1'b1, bp_pc, make_inst(2'd2, next_rand()), 1'b1, bp_pc,
              1'b1, 32'h0000_6000);
    check_kind("pred_kind_o", pred_kind, PRED_SEQ);
    run_cycle(1'b0, 1'b0, bp_pc, make_inst(2'd2, next_rand()), 1'b0, '0, 1'b0, '0);
    check_kind("pred_kind_o", pred_kind, PRED_SEQ);
    fetch_only(bp_pc, make_inst(2'd0, next_rand()));
    check_addr("pred_pc_o", pred_pc, 32'h0000_3000);

    // Not-taken report moves the history off the trained counter
    report_only(bp_pc, 1'b0, 32'h0000_3000);
    fetch_only(bp_pc, make_inst(2'd0, next_rand()));
    check_kind("pred_kind_o", pred_kind, PRED_SEQ);

    // ========================================
    // Random mix
    // ========================================
    for (int n = 0; n < N_RANDOM; n++) begin
      r = next_rand();
      run_cycle(r[2:0] != 3'd0, r[5:3] == 3'd0, pool_pc(r[12:8]),
                make_inst(r[7:6], next_rand()), r[13], pool_pc(r[20:16]),
                r[15:14] != 2'd0, next_rand() & 32'hffff_fffc);
    end

    $display("Test passed");
    $finish;
  end

endmodule

/* verification/tb_clock.sv */
// Testbench clock and reset
`timescale 1ns/100ps

module tb_clock #(
  parameter int unsigned HALF_PERIOD_NS = 50,
  parameter int unsigned RESET_CYCLES   = 2
) (
  output logic clk_o,
  output logic rst_no
);

  // 100 ns period
  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
  end

  // Low for the first rising edges, released on an edge
  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

/* source/gshare_bp.sv */
// Gshare branch predictor top level
// Same-cycle next-PC prediction for fetch
`timescale 1ns/100ps

module gshare_bp #(
  parameter int unsigned PHT_ENTRIES = 64,
  parameter int unsigned BTB_ENTRIES = 16,
  parameter int unsigned GHR_BITS    = 6
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               stall_i,
  input  logic               fetch_valid_i,
  input  bp_pkg::addr_t      pc_i,
  input  bp_pkg::inst_t      inst_i,
  input  logic               resolve_valid_i,
  input  bp_pkg::addr_t      resolve_pc_i,
  input  logic               resolve_taken_i,
  input  bp_pkg::addr_t      resolve_target_i,
  output bp_pkg::addr_t      pred_pc_o,
  output logic               pred_taken_o,
  output bp_pkg::pred_kind_e pred_kind_o
);
  import bp_pkg::*;

  opcode_e opcode;
  addr_t   offset;
  addr_t   seq_pc;
  logic    pht_taken;
  logic    btb_hit;
  addr_t   btb_target;

  bp_resolve_if resolve_bus ();

  // ========================================
  // Resolve report, frozen while stalled
  // ========================================
  assign resolve_bus.valid  = resolve_valid_i && !stall_i;
  assign resolve_bus.pc     = resolve_pc_i;
  assign resolve_bus.taken  = resolve_taken_i;
  assign resolve_bus.target = resolve_target_i;

  bp_decode i_bp_decode (
    .inst_i   (inst_i),
    .opcode_o (opcode),
    .offset_o (offset)
  );

  pht_ghr #(
    .PHT_ENTRIES (PHT_ENTRIES),
    .GHR_BITS    (GHR_BITS)
  ) i_pht_ghr (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .fetch_pc_i (pc_i),
    .resolve    (resolve_bus),
    .taken_o    (pht_taken)
  );

  btb #(
    .BTB_ENTRIES (BTB_ENTRIES)
  ) i_btb (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .fetch_pc_i (pc_i),
    .resolve    (resolve_bus),
    .hit_o      (btb_hit),
    .target_o   (btb_target)
  );

  // ========================================
  // Next-PC select
  // ========================================
  assign seq_pc = pc_i + addr_t'(INST_BYTES);

  always_comb begin
    // Fall-through unless a valid, unstalled fetch says otherwise
    pred_pc_o    = seq_pc;
    pred_taken_o = 1'b0;
    pred_kind_o  = PRED_SEQ;
    if (fetch_valid_i && !stall_i) begin
      if (opcode == OP_JAL) begin
        // Direct jump always taken
        pred_pc_o    = pc_i + offset;
        pred_taken_o = 1'b1;
        pred_kind_o  = PRED_JAL;
      end else if (opcode == OP_BRANCH && pht_taken && btb_hit) begin
        // Needs both direction and a known target
        pred_pc_o    = btb_target;
        pred_taken_o = 1'b1;
        pred_kind_o  = PRED_BRANCH;
      end
    end
  end

endmodule

/* source/btb.sv */
// Direct-mapped branch target buffer
`timescale 1ns/100ps

module btb #(
  parameter int unsigned BTB_ENTRIES = 16
) (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  bp_pkg::addr_t fetch_pc_i,
  bp_resolve_if.sink    resolve,
  output logic          hit_o,
  output bp_pkg::addr_t target_o
);
  import bp_pkg::*;

  localparam int unsigned IDX_BITS = $clog2(BTB_ENTRIES);
  localparam int unsigned PC_LSB   = $clog2(INST_BYTES);
  // Everything above the index is tag
  localparam int unsigned TAG_LSB  = PC_LSB + IDX_BITS;
  localparam int unsigned TAG_BITS = XLEN - TAG_LSB;

  // Valid bits are control state, tag and target are payload
  logic                valid_q  [BTB_ENTRIES];
  logic [TAG_BITS-1:0] tag_q    [BTB_ENTRIES];
  addr_t               target_q [BTB_ENTRIES];

  logic [IDX_BITS-1:0] rd_idx;
  logic [IDX_BITS-1:0] wr_idx;

  // ========================================
  // Lookup
  // ========================================
  assign rd_idx   = fetch_pc_i[PC_LSB +: IDX_BITS];
  assign hit_o    = valid_q[rd_idx] && (tag_q[rd_idx] == fetch_pc_i[XLEN-1:TAG_LSB]);
  assign target_o = target_q[rd_idx];

  // ========================================
  // Fill on taken reports only
  // ========================================
  assign wr_idx = resolve.pc[PC_LSB +: IDX_BITS];

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      for (int i = 0; i < BTB_ENTRIES; i++) begin
        valid_q[i] <= 1'b0;
      end
    end else if (resolve.valid && resolve.taken) begin
      valid_q[wr_idx] <= 1'b1;
    end
  end

  // Payload, overwritten on every taken report for this index
  always_ff @(posedge clk_i) begin
    if (resolve.valid && resolve.taken) begin
      tag_q[wr_idx]    <= resolve.pc[XLEN-1:TAG_LSB];
      target_q[wr_idx] <= resolve.target;
    end
  end

endmodule

/* source/pht_ghr.sv */
// Gshare direction predictor
// Counter table plus global history
`timescale 1ns/100ps

module pht_ghr #(
  parameter int unsigned PHT_ENTRIES = 64,
  parameter int unsigned GHR_BITS    = 6
) (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  bp_pkg::addr_t fetch_pc_i,
  bp_resolve_if.sink    resolve,
  output logic          taken_o
);
  import bp_pkg::*;

  localparam int unsigned IDX_BITS = $clog2(PHT_ENTRIES);
  // Word offset bits skipped in the index
  localparam int unsigned PC_LSB   = $clog2(INST_BYTES);

  // ========================================
  // State
  // ========================================
  ctr_t                ctr_q [PHT_ENTRIES];
  logic [GHR_BITS-1:0] ghr_q;

  logic [IDX_BITS-1:0] ghr_ext;
  logic [IDX_BITS-1:0] rd_idx;
  logic [IDX_BITS-1:0] wr_idx;
  ctr_t                wr_ctr;
  ctr_t                wr_ctr_next;

  // History zero-extended to index width
  assign ghr_ext = IDX_BITS'(ghr_q);

  // ========================================
  // Lookup
  // ========================================
  // PC bits above the word offset XOR history
  assign rd_idx  = fetch_pc_i[PC_LSB +: IDX_BITS] ^ ghr_ext;
  assign taken_o = ctr_q[rd_idx][1];

  // ========================================
  // Training
  // ========================================
  // Same hash on the report PC, history before this edge's shift
  assign wr_idx = resolve.pc[PC_LSB +: IDX_BITS] ^ ghr_ext;
  assign wr_ctr = ctr_q[wr_idx];

  // Saturate at both ends
  always_comb begin
    wr_ctr_next = wr_ctr;
    if (resolve.taken) begin
      if (wr_ctr != 2'b11) begin
        wr_ctr_next = wr_ctr + 2'b01;
      end
    end else if (wr_ctr != 2'b00) begin
      wr_ctr_next = wr_ctr - 2'b01;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      ghr_q <= '0;
      for (int i = 0; i < PHT_ENTRIES; i++) begin
        ctr_q[i] <= CTR_RESET;
      end
    end else if (resolve.valid) begin
      ctr_q[wr_idx] <= wr_ctr_next;
      // Newest outcome enters at the LSB, oldest drops off the top
      ghr_q         <= GHR_BITS'({ghr_q, resolve.taken});
    end
  end

endmodule

/* source/bp_decode.sv */
// Fetch instruction pre-decode
`timescale 1ns/100ps

module bp_decode (
  input  bp_pkg::inst_t   inst_i,
  output bp_pkg::opcode_e opcode_o,
  output bp_pkg::addr_t   offset_o
);
  import bp_pkg::*;

  opcode_e opcode;

  // Opcode field straight from the low bits
  // Unlisted encodings fall through as "other"
  assign opcode   = opcode_e'(inst_i[6:0]);
  assign opcode_o = opcode;

  // ========================================
  // Immediate extraction
  // ========================================
  always_comb begin
    case (opcode)
      OP_BRANCH: begin
        // B-type, imm[12|10:5|4:1|11], bit 0 implied zero
        offset_o = {{(XLEN-12){inst_i[31]}}, inst_i[7], inst_i[30:25],
                    inst_i[11:8], 1'b0};
      end
      OP_JAL: begin
        // J-type, imm[20|10:1|11|19:12]
        offset_o = {{(XLEN-20){inst_i[31]}}, inst_i[19:12], inst_i[20],
                    inst_i[30:21], 1'b0};
      end
      default: begin
        // No PC-relative target
        offset_o = '0;
      end
    endcase
  end

endmodule

/* source/bp_resolve_if.sv */
// Resolved branch report bus
`timescale 1ns/100ps

interface bp_resolve_if;
  import bp_pkg::*;

  // Report already qualified with stall by the top level
  logic  valid;
  // Branch PC from execute
  addr_t pc;
  // Actual direction
  logic  taken;
  // Actual target, meaningful when taken
  addr_t target;

  // Top level drives the report
  modport source (
    output valid, pc, taken, target
  );

  // Prediction tables consume it
  modport sink (
    input valid, pc, taken, target
  );

endinterface

/* source/bp_pkg.sv */
// Branch predictor shared types
// Architectural constants and encodings

package bp_pkg;

  // RV32 word and instruction size
  localparam int unsigned XLEN       = 32;
  localparam int unsigned INST_BYTES = 4;

  typedef logic [XLEN-1:0] addr_t;
  typedef logic [31:0]     inst_t;

  // Major opcode field, inst[6:0]
  // Values not named here are treated as non-control-flow
  typedef enum logic [6:0] {
    OP_BRANCH = 7'b1100011,
    OP_JAL    = 7'b1101111
  } opcode_e;

  // Where the next-PC prediction came from
  typedef enum logic [1:0] {
    PRED_SEQ    = 2'd0,
    PRED_JAL    = 2'd1,
    PRED_BRANCH = 2'd2
  } pred_kind_e;

  // 2-bit saturating direction counter
  // MSB set means predict taken
  typedef logic [1:0] ctr_t;

  // Weakly not-taken
  localparam ctr_t CTR_RESET = 2'b01;

endpackage
